// ==== ptw_config.svh ====
// queue depth, address, page and table index widths of the page-table walker
`ifndef PTW_CONFIG_SVH
`define PTW_CONFIG_SVH

`default_nettype none

// ============================================================
// miss queue
// ============================================================
`define PTW_MISSQ_SIZE 8

// ============================================================
// address and field widths
// ============================================================
`define PTW_ADR_W 32
`define PTW_ASID_W 8

// 8 KiB pages
`define PTW_PAGE_SHIFT 13

// two-level table, 8-byte PTEs
`define PTW_L0_BITS 10
`define PTW_L1_BITS 9
`define PTW_PTE_SHIFT 3

`default_nettype wire

`endif

// ==== ptw_mmu_pkg.sv ====
// MMU address, page number, ASID and table level types
`include "ptw_config.svh"

`default_nettype none

package ptw_mmu_pkg;

	// ============================================================
	// addresses and page numbers
	// ============================================================
	typedef logic [`PTW_ADR_W-1:0] address_t;

	// virtual page number, the address bits above the page offset
	typedef logic [`PTW_ADR_W-`PTW_PAGE_SHIFT-1:0] vpn_t;

	// physical page number as returned in a PTE
	typedef logic [`PTW_ADR_W-`PTW_PAGE_SHIFT-1:0] ppn_t;

	typedef logic [`PTW_ASID_W-1:0] asid_t;

	// ============================================================
	// table levels
	// ============================================================
	// 1 is the top table, 0 holds the leaf PTEs
	typedef logic level_t;

	localparam level_t LVL_TOP  = 1'b1;
	localparam level_t LVL_LEAF = 1'b0;

endpackage

`default_nettype wire

// ==== ptw_queue_pkg.sv ====
// miss queue index type and miss queue entry struct
`include "ptw_config.svh"

`default_nettype none

package ptw_queue_pkg;

	// ============================================================
	// queue index
	// ============================================================
	typedef logic [$clog2(`PTW_MISSQ_SIZE)-1:0] mq_ndx_t;

	// ============================================================
	// one miss queue entry
	// ============================================================
	typedef struct packed {
		// entry holds a pending miss
		logic valid;
		// a walk request is in flight for this entry
		logic outstanding;
		// level of the table entry named by tadr
		ptw_mmu_pkg::level_t level;
		ptw_mmu_pkg::asid_t asid;
		// missing virtual address
		ptw_mmu_pkg::address_t vadr;
		// address of the next table entry to read
		ptw_mmu_pkg::address_t tadr;
	} mq_entry_t;

endpackage

`default_nettype wire

// ==== ptw_miss_match.sv ====
// duplicate and free entry search, first table address, in_que and miss_drop strobes
`include "ptw_config.svh"

`default_nettype none

module ptw_miss_match (
	input  logic clk,
	input  logic rst,
	input  logic tlb_miss,
	input  ptw_mmu_pkg::asid_t miss_asid,
	input  ptw_mmu_pkg::address_t miss_adr,
	input  ptw_mmu_pkg::address_t ptbr_base,
	input  ptw_mmu_pkg::level_t ptbr_level,
	input  ptw_queue_pkg::mq_entry_t [`PTW_MISSQ_SIZE-1:0] entries,
	output logic alloc,
	output ptw_queue_pkg::mq_ndx_t alloc_ndx,
	output ptw_queue_pkg::mq_entry_t alloc_entry,
	output logic in_que,
	output logic miss_drop
);
	import ptw_mmu_pkg::*;
	import ptw_queue_pkg::*;

	logic hit;
	logic free_found;
	mq_ndx_t free_ndx;
	vpn_t miss_vpn;
	address_t l1_off;
	address_t l0_off;
	address_t first_tadr;

	assign miss_vpn = miss_adr[`PTW_ADR_W-1:`PTW_PAGE_SHIFT];

	// ============================================================
	// search the queue
	// ============================================================
	// same ASID and same virtual page is a duplicate
	always_comb begin
		hit = 1'b0;
		for (int i = 0; i < `PTW_MISSQ_SIZE; i++) begin
			if (entries[i].valid && entries[i].asid == miss_asid &&
				entries[i].vadr[`PTW_ADR_W-1:`PTW_PAGE_SHIFT] == miss_vpn) begin
				hit = 1'b1;
			end
		end
	end

	// scan downwards so the lowest free index wins
	always_comb begin
		free_found = 1'b0;
		free_ndx = '0;
		for (int i = `PTW_MISSQ_SIZE - 1; i >= 0; i--) begin
			if (!entries[i].valid) begin
				free_found = 1'b1;
				free_ndx = mq_ndx_t'(i);
			end
		end
	end

	// ============================================================
	// new entry
	// ============================================================
	// PTE offsets into the top and leaf tables
	assign l1_off = address_t'({miss_adr[`PTW_ADR_W-1 -: `PTW_L1_BITS],
		{`PTW_PTE_SHIFT{1'b0}}});
	assign l0_off = address_t'({miss_adr[`PTW_PAGE_SHIFT +: `PTW_L0_BITS],
		{`PTW_PTE_SHIFT{1'b0}}});

	assign first_tadr = ptbr_base + ((ptbr_level == LVL_TOP) ? l1_off : l0_off);

	always_comb begin
		alloc_entry.valid = 1'b1;
		alloc_entry.outstanding = 1'b0;
		alloc_entry.level = ptbr_level;
		alloc_entry.asid = miss_asid;
		alloc_entry.vadr = miss_adr;
		alloc_entry.tadr = first_tadr;
	end

	assign alloc = tlb_miss && !hit && free_found;
	assign alloc_ndx = free_ndx;

	// status strobes, one cycle after the miss
	always_ff @(posedge clk) begin
		if (rst) begin
			in_que <= 1'b0;
			miss_drop <= 1'b0;
		end else begin
			in_que <= tlb_miss && hit;
			miss_drop <= tlb_miss && !hit && !free_found;
		end
	end

endmodule

`default_nettype wire

// ==== ptw_walk_select.sv ====
// next unissued entry select and registered walk request
`include "ptw_config.svh"

`default_nettype none

module ptw_walk_select (
	input  logic clk,
	input  logic rst,
	input  ptw_queue_pkg::mq_entry_t [`PTW_MISSQ_SIZE-1:0] entries,
	output logic issue,
	output ptw_queue_pkg::mq_ndx_t issue_ndx,
	output logic walk_req,
	output ptw_queue_pkg::mq_ndx_t walk_ndx,
	output ptw_mmu_pkg::address_t walk_tadr
);
	import ptw_queue_pkg::*;

	logic found;
	mq_ndx_t sel_ndx;

	// lowest entry that waits for a walk
	always_comb begin
		found = 1'b0;
		sel_ndx = '0;
		for (int i = `PTW_MISSQ_SIZE - 1; i >= 0; i--) begin
			if (entries[i].valid && !entries[i].outstanding) begin
				found = 1'b1;
				sel_ndx = mq_ndx_t'(i);
			end
		end
	end

	// store marks it outstanding at the same edge as the request
	assign issue = found;
	assign issue_ndx = sel_ndx;

	always_ff @(posedge clk) begin
		if (rst)
			walk_req <= 1'b0;
		else
			walk_req <= found;
	end

	always_ff @(posedge clk) begin
		if (found) begin
			walk_ndx <= sel_ndx;
			walk_tadr <= entries[sel_ndx].tadr;
		end
	end

endmodule

`default_nettype wire

// ==== ptw_pte_update.sv ====
// PTE response handling, level-0 table address and completed translation
`include "ptw_config.svh"

`default_nettype none

module ptw_pte_update (
	input  logic clk,
	input  logic rst,
	input  logic pte_valid,
	input  ptw_queue_pkg::mq_ndx_t pte_ndx,
	input  ptw_mmu_pkg::ppn_t pte_ppn,
	input  ptw_queue_pkg::mq_entry_t [`PTW_MISSQ_SIZE-1:0] entries,
	output logic descend,
	output ptw_queue_pkg::mq_ndx_t descend_ndx,
	output ptw_mmu_pkg::address_t descend_tadr,
	output logic retire,
	output ptw_queue_pkg::mq_ndx_t retire_ndx,
	output logic tlb_update,
	output ptw_mmu_pkg::asid_t upd_asid,
	output ptw_mmu_pkg::vpn_t upd_vpn,
	output ptw_mmu_pkg::ppn_t upd_ppn
);
	import ptw_mmu_pkg::*;
	import ptw_queue_pkg::*;

	mq_entry_t resp;

	// entry the response belongs to
	assign resp = entries[pte_ndx];

	// ============================================================
	// top table response
	// ============================================================
	// PPN names the leaf table, index it with the level-0 bits
	assign descend = pte_valid && (resp.level == LVL_TOP);
	assign descend_ndx = pte_ndx;
	assign descend_tadr = {pte_ppn, resp.vadr[`PTW_PAGE_SHIFT +: `PTW_L0_BITS],
		{`PTW_PTE_SHIFT{1'b0}}};

	// ============================================================
	// leaf table response
	// ============================================================
	// entry is freed at the response edge
	assign retire = pte_valid && (resp.level == LVL_LEAF);
	assign retire_ndx = pte_ndx;

	always_ff @(posedge clk) begin
		if (rst)
			tlb_update <= 1'b0;
		else
			tlb_update <= retire;
	end

	// translation for the TLB
	always_ff @(posedge clk) begin
		if (retire) begin
			upd_asid <= resp.asid;
			upd_vpn <= resp.vadr[`PTW_ADR_W-1:`PTW_PAGE_SHIFT];
			upd_ppn <= pte_ppn;
		end
	end

endmodule

`default_nettype wire

// ==== ptw_miss_store.sv ====
// miss queue entry array with allocate, issue, descend and retire writes
`include "ptw_config.svh"

`default_nettype none

module ptw_miss_store (
	input  logic clk,
	input  logic rst,
	// new miss
	input  logic alloc,
	input  ptw_queue_pkg::mq_ndx_t alloc_ndx,
	input  ptw_queue_pkg::mq_entry_t alloc_entry,
	// walk request sent
	input  logic issue,
	input  ptw_queue_pkg::mq_ndx_t issue_ndx,
	// top level response
	input  logic descend,
	input  ptw_queue_pkg::mq_ndx_t descend_ndx,
	input  ptw_mmu_pkg::address_t descend_tadr,
	// leaf response
	input  logic retire,
	input  ptw_queue_pkg::mq_ndx_t retire_ndx,
	output ptw_queue_pkg::mq_entry_t [`PTW_MISSQ_SIZE-1:0] entries
);
	import ptw_mmu_pkg::*;

	// ============================================================
	// entry array
	// ============================================================
	// the four writes target different entries in any one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			entries <= '0;
		end else begin
			// only an invalid entry is allocated
			if (alloc)
				entries[alloc_ndx] <= alloc_entry;

			// only an idle entry is issued
			if (issue)
				entries[issue_ndx].outstanding <= 1'b1;

			// walk continues in the leaf table
			if (descend) begin
				entries[descend_ndx].level <= LVL_LEAF;
				entries[descend_ndx].tadr <= descend_tadr;
				entries[descend_ndx].outstanding <= 1'b0;
			end

			// translation done, entry is free again
			if (retire) begin
				entries[retire_ndx].valid <= 1'b0;
				entries[retire_ndx].outstanding <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== ptw_miss_queue_top.sv ====
// page-table walker miss queue top level with match, select, update and store blocks
`include "ptw_config.svh"

`default_nettype none

module ptw_miss_queue_top (
	input  logic clk,
	input  logic rst,
	// TLB miss
	input  logic tlb_miss,
	input  ptw_mmu_pkg::asid_t miss_asid,
	input  ptw_mmu_pkg::address_t miss_adr,
	input  ptw_mmu_pkg::address_t ptbr_base,
	input  ptw_mmu_pkg::level_t ptbr_level,
	output logic in_que,
	output logic miss_drop,
	// walk request
	output logic walk_req,
	output ptw_queue_pkg::mq_ndx_t walk_ndx,
	output ptw_mmu_pkg::address_t walk_tadr,
	// PTE response
	input  logic pte_valid,
	input  ptw_queue_pkg::mq_ndx_t pte_ndx,
	input  ptw_mmu_pkg::ppn_t pte_ppn,
	// TLB update
	output logic tlb_update,
	output ptw_mmu_pkg::asid_t upd_asid,
	output ptw_mmu_pkg::vpn_t upd_vpn,
	output ptw_mmu_pkg::ppn_t upd_ppn
);
	import ptw_mmu_pkg::*;
	import ptw_queue_pkg::*;

	mq_entry_t [`PTW_MISSQ_SIZE-1:0] entries;
	logic alloc;
	mq_ndx_t alloc_ndx;
	mq_entry_t alloc_entry;
	logic issue;
	mq_ndx_t issue_ndx;
	logic descend;
	mq_ndx_t descend_ndx;
	address_t descend_tadr;
	logic retire;
	mq_ndx_t retire_ndx;

	ptw_miss_match ptw_miss_match_inst (
		.clk(clk),
		.rst(rst),
		.tlb_miss(tlb_miss),
		.miss_asid(miss_asid),
		.miss_adr(miss_adr),
		.ptbr_base(ptbr_base),
		.ptbr_level(ptbr_level),
		.entries(entries),
		.alloc(alloc),
		.alloc_ndx(alloc_ndx),
		.alloc_entry(alloc_entry),
		.in_que(in_que),
		.miss_drop(miss_drop)
	);

	ptw_walk_select ptw_walk_select_inst (
		.clk(clk),
		.rst(rst),
		.entries(entries),
		.issue(issue),
		.issue_ndx(issue_ndx),
		.walk_req(walk_req),
		.walk_ndx(walk_ndx),
		.walk_tadr(walk_tadr)
	);

	ptw_pte_update ptw_pte_update_inst (
		.clk(clk),
		.rst(rst),
		.pte_valid(pte_valid),
		.pte_ndx(pte_ndx),
		.pte_ppn(pte_ppn),
		.entries(entries),
		.descend(descend),
		.descend_ndx(descend_ndx),
		.descend_tadr(descend_tadr),
		.retire(retire),
		.retire_ndx(retire_ndx),
		.tlb_update(tlb_update),
		.upd_asid(upd_asid),
		.upd_vpn(upd_vpn),
		.upd_ppn(upd_ppn)
	);

	ptw_miss_store ptw_miss_store_inst (
		.clk(clk),
		.rst(rst),
		.alloc(alloc),
		.alloc_ndx(alloc_ndx),
		.alloc_entry(alloc_entry),
		.issue(issue),
		.issue_ndx(issue_ndx),
		.descend(descend),
		.descend_ndx(descend_ndx),
		.descend_tadr(descend_tadr),
		.retire(retire),
		.retire_ndx(retire_ndx),
		.entries(entries)
	);

endmodule

`default_nettype wire

// ==== tb_ptw_assertions.sv ====
// concurrent checks on walk requests, PTE responses and status strobes of the miss queue
`include "ptw_config.svh"

`default_nettype none

module tb_ptw_assertions (
	input  logic clk,
	input  logic rst,
	input  logic tlb_miss,
	input  logic in_que,
	input  logic walk_req,
	input  ptw_queue_pkg::mq_ndx_t walk_ndx,
	input  logic pte_valid,
	input  ptw_queue_pkg::mq_ndx_t pte_ndx,
	input  logic tlb_update
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [`PTW_MISSQ_SIZE-1:0] pend;
	int fail_cnt = 0;

	// indices with a walk request that has not been answered yet
	// a response in the same cycle as its request answers that request
	always_ff @(posedge clk) begin
		if (rst) begin
			pend <= '0;
		end else begin
			if (walk_req)
				pend[walk_ndx] <= 1'b1;
			if (pte_valid)
				pend[pte_ndx] <= 1'b0;
		end
	end

	// ============================================================
	// walk requests
	// ============================================================
	walk_not_pending: assert property (@(posedge clk) disable iff (rst)
		walk_req |-> !pend[walk_ndx])
		else begin
			fail_cnt++;
			$error("walk request names an index whose response is pending");
		end

	// back to back requests always name different entries
	walk_one_per_ndx: assert property (@(posedge clk) disable iff (rst)
		walk_req |=> !walk_req || walk_ndx != $past(walk_ndx))
		else begin
			fail_cnt++;
			$error("walk request for one index held over two cycles");
		end

	// ============================================================
	// status strobes
	// ============================================================
	quiet_in_reset: assert property (@(posedge clk)
		rst |=> !tlb_update && !in_que)
		else begin
			fail_cnt++;
			$error("tlb_update or in_que pulsed during reset");
		end

	// each update cycle answers exactly one response
	upd_per_pte: assert property (@(posedge clk) disable iff (rst)
		tlb_update |-> $past(pte_valid))
		else begin
			fail_cnt++;
			$error("tlb_update without a PTE response in the cycle before");
		end

	in_que_per_miss: assert property (@(posedge clk) disable iff (rst)
		in_que |-> $past(tlb_miss))
		else begin
			fail_cnt++;
			$error("in_que without a TLB miss in the cycle before");
		end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// testbench clock and reset generator
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 1ps;

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// reset held over two rising edges, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// ==== tb_ptw_miss_queue.sv ====
// testbench with random misses, page-table model, out-of-order PTE responder and watchdog
`include "ptw_config.svh"

`default_nettype none

module tb_ptw_miss_queue;
	timeunit 1ns;
	timeprecision 1ps;

	import ptw_mmu_pkg::*;
	import ptw_queue_pkg::*;

	localparam int N = `PTW_MISSQ_SIZE;
	localparam int N_RAND = 60;
	localparam int N_MISS = 2 * N_RAND + N + 5;

	logic clk;
	logic rst;
	logic tlb_miss;
	asid_t miss_asid;
	address_t miss_adr;
	address_t ptbr_base;
	level_t ptbr_level;
	logic in_que;
	logic miss_drop;
	logic walk_req;
	mq_ndx_t walk_ndx;
	address_t walk_tadr;
	logic pte_valid;
	mq_ndx_t pte_ndx;
	ppn_t pte_ppn;
	logic tlb_update;
	asid_t upd_asid;
	vpn_t upd_vpn;
	ppn_t upd_ppn;

	// queue model, one slot per DUT entry
	logic m_valid [N];
	logic m_wait [N];
	level_t m_level [N];
	asid_t m_asid [N];
	address_t m_vadr [N];
	address_t m_tadr [N];
	mq_ndx_t pending [$];

	logic exp_in_que;
	logic exp_drop;
	logic exp_upd;
	asid_t exp_asid;
	vpn_t exp_vpn;
	ppn_t exp_ppn;
	logic resp_en;
	logic [31:0] lfsr;
	int val_errs;
	int proto_errs;
	int asrt_errs;
	int drops_seen;
	int dups_seen;
	int max_inflight;

	tb_clk_gen tb_clk_gen_inst (
		.clk(clk),
		.rst(rst)
	);

	ptw_miss_queue_top ptw_miss_queue_top_inst (
		.clk(clk),
		.rst(rst),
		.tlb_miss(tlb_miss),
		.miss_asid(miss_asid),
		.miss_adr(miss_adr),
		.ptbr_base(ptbr_base),
		.ptbr_level(ptbr_level),
		.in_que(in_que),
		.miss_drop(miss_drop),
		.walk_req(walk_req),
		.walk_ndx(walk_ndx),
		.walk_tadr(walk_tadr),
		.pte_valid(pte_valid),
		.pte_ndx(pte_ndx),
		.pte_ppn(pte_ppn),
		.tlb_update(tlb_update),
		.upd_asid(upd_asid),
		.upd_vpn(upd_vpn),
		.upd_ppn(upd_ppn)
	);

	bind ptw_miss_queue_top tb_ptw_assertions tb_ptw_assertions_inst (
		.clk(clk),
		.rst(rst),
		.tlb_miss(tlb_miss),
		.in_que(in_que),
		.walk_req(walk_req),
		.walk_ndx(walk_ndx),
		.pte_valid(pte_valid),
		.pte_ndx(pte_ndx),
		.tlb_update(tlb_update)
	);

	// ============================================================
	// random numbers and page-table model
	// ============================================================
	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic ppn_t table_ppn(input address_t tadr);
		return tadr[21:3] ^ 19'h2a5a5;
	endfunction

	function automatic address_t first_tadr(input address_t base, input level_t lvl,
		input address_t va);
		if (lvl)
			return base + {va[31:23], 3'b000};
		return base + {va[22:13], 3'b000};
	endfunction

	function automatic int model_count();
		int c;
		c = 0;
		for (int i = 0; i < N; i++)
			if (m_valid[i])
				c++;
		return c;
	endfunction

	// ============================================================
	// compare tasks
	// ============================================================
	task automatic check_adr(input string name, input address_t got, input address_t exp);
		if (got !== exp) begin
			val_errs++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_ppn(input string name, input ppn_t got, input ppn_t exp);
		if (got !== exp) begin
			val_errs++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_asid(input string name, input asid_t got, input asid_t exp);
		if (got !== exp) begin
			val_errs++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_vpn(input string name, input vpn_t got, input vpn_t exp);
		if (got !== exp) begin
			val_errs++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			val_errs++;
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// ============================================================
	// per-cycle observe, miss and response
	// ============================================================
	task automatic observe();
		check_bit("in_que", in_que, exp_in_que);
		check_bit("miss_drop", miss_drop, exp_drop);
		check_bit("tlb_update", tlb_update, exp_upd);
		if (in_que === 1'b1)
			dups_seen++;
		if (miss_drop === 1'b1)
			drops_seen++;
		if (tlb_update === 1'b1 && exp_upd) begin
			check_asid("upd_asid", upd_asid, exp_asid);
			check_vpn("upd_vpn", upd_vpn, exp_vpn);
			check_ppn("upd_ppn", upd_ppn, exp_ppn);
		end
		if ($isunknown(walk_req)) begin
			proto_errs++;
			$display("%0t walk_req is unknown", $time);
		end else if (walk_req) begin
			if (!m_valid[walk_ndx] || !m_wait[walk_ndx]) begin
				proto_errs++;
				$display("%0t walk request for index %0d which has no walk due", $time, walk_ndx);
			end else begin
				check_adr("walk_tadr", walk_tadr, m_tadr[walk_ndx]);
				m_wait[walk_ndx] = 1'b0;
				pending.push_back(walk_ndx);
				if (pending.size() > max_inflight)
					max_inflight = pending.size();
			end
		end
		exp_in_que = 1'b0;
		exp_drop = 1'b0;
		exp_upd = 1'b0;
	endtask

	task automatic apply_miss(input asid_t asid, input address_t adr);
		int slot;
		logic hit;
		hit = 1'b0;
		slot = -1;
		for (int i = N - 1; i >= 0; i--) begin
			if (m_valid[i] && m_asid[i] == asid && m_vadr[i][31:13] == adr[31:13])
				hit = 1'b1;
			if (!m_valid[i])
				slot = i;
		end
		tlb_miss = 1'b1;
		miss_asid = asid;
		miss_adr = adr;
		if (hit) begin
			exp_in_que = 1'b1;
		end else if (slot < 0) begin
			exp_drop = 1'b1;
		end else begin
			m_valid[slot] = 1'b1;
			m_wait[slot] = 1'b1;
			m_level[slot] = ptbr_level;
			m_asid[slot] = asid;
			m_vadr[slot] = adr;
			m_tadr[slot] = first_tadr(ptbr_base, ptbr_level, adr);
		end
	endtask

	// answers a random pending walk, so responses come back out of order
	task automatic respond();
		int k;
		mq_ndx_t ndx;
		ppn_t ppn;
		pte_valid = 1'b0;
		if (!resp_en || pending.size() == 0 || rand_bits(1) == 0)
			return;
		k = rand_bits(3) % pending.size();
		ndx = pending[k];
		pending.delete(k);
		ppn = table_ppn(m_tadr[ndx]);
		pte_valid = 1'b1;
		pte_ndx = ndx;
		pte_ppn = ppn;
		if (m_level[ndx]) begin
			m_level[ndx] = 1'b0;
			m_tadr[ndx] = {ppn, m_vadr[ndx][22:13], 3'b000};
			m_wait[ndx] = 1'b1;
		end else begin
			m_valid[ndx] = 1'b0;
			exp_upd = 1'b1;
			exp_asid = m_asid[ndx];
			exp_vpn = m_vadr[ndx][31:13];
			exp_ppn = ppn;
		end
	endtask

	// the miss is modelled before the response of the same cycle
	task automatic step(input logic do_miss, input asid_t asid, input address_t adr);
		@(negedge clk);
		observe();
		tlb_miss = 1'b0;
		if (do_miss)
			apply_miss(asid, adr);
		respond();
	endtask

	task automatic drain();
		while (model_count() > 0)
			step(1'b0, '0, '0);
		step(1'b0, '0, '0);
	endtask

	// small page and ASID pools so duplicates and a full queue happen
	task automatic random_misses(input int count);
		logic [31:0] r;
		asid_t asid;
		for (int m = 0; m < count; m++) begin
			repeat (rand_bits(2)) step(1'b0, '0, '0);
			asid = rand_bits(1) ? 8'h11 : 8'h5c;
			r = rand_bits(17);
			step(1'b1, asid, {r[16:15], 7'h2b, r[14:13], 8'hc6, r[12:0]});
		end
	endtask

	// one page under two ASIDs, then a repeat of the first while both are pending
	task automatic asid_alias();
		resp_en = 1'b0;
		step(1'b1, 8'h21, 32'h0a4b_6000);
		step(1'b1, 8'h22, 32'h0a4b_6000);
		step(1'b1, 8'h21, 32'h0a4b_7fff);
		resp_en = 1'b1;
		drain();
	endtask

	// nine distinct misses with no responses, then one more after a retire
	task automatic fill_and_drop();
		resp_en = 1'b0;
		for (int i = 0; i <= N; i++)
			step(1'b1, 8'h77, {i[3:0], 28'h35a_1000});
		repeat (3) step(1'b0, '0, '0);
		resp_en = 1'b1;
		while (model_count() == N)
			step(1'b0, '0, '0);
		step(1'b1, 8'h77, 32'hf35a_1000);
		drain();
	endtask

	// ============================================================
	// watchdog
	// ============================================================
	initial begin
		repeat (N_MISS * 200) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", N_MISS * 200);
		$display("Simulation FAILED");
		$finish;
	end

	// ============================================================
	// main sequence
	// ============================================================
	initial begin
		lfsr = 32'd81156;
		tlb_miss = 1'b0;
		miss_asid = '0;
		miss_adr = '0;
		ptbr_base = 32'h0040_0000;
		ptbr_level = 1'b1;
		pte_valid = 1'b0;
		pte_ndx = '0;
		pte_ppn = '0;
		resp_en = 1'b1;
		exp_in_que = 1'b0;
		exp_drop = 1'b0;
		exp_upd = 1'b0;
		val_errs = 0;
		proto_errs = 0;
		drops_seen = 0;
		dups_seen = 0;
		max_inflight = 0;
		for (int i = 0; i < N; i++) begin
			m_valid[i] = 1'b0;
			m_wait[i] = 1'b0;
		end
		wait (rst === 1'b0);

		// strobes stay low while idle
		repeat (4) step(1'b0, '0, '0);

		random_misses(N_RAND);
		drain();

		// start the walk in the leaf table
		ptbr_base = 32'h0120_0000;
		ptbr_level = 1'b0;
		random_misses(N_RAND);
		drain();

		ptbr_base = 32'h0040_0000;
		ptbr_level = 1'b1;
		asid_alias();
		fill_and_drop();

		if (drops_seen == 0 || dups_seen == 0 || max_inflight < 2) begin
			proto_errs++;
			$display("no drop, no duplicate or never two walks in flight");
		end
		asrt_errs = ptw_miss_queue_top_inst.tb_ptw_assertions_inst.fail_cnt;
		$display("errors: %0d value, %0d protocol, %0d assertion",
			val_errs, proto_errs, asrt_errs);
		if (val_errs + proto_errs + asrt_errs == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
ptw_mmu_pkg.sv
ptw_queue_pkg.sv
ptw_miss_match.sv
ptw_walk_select.sv
ptw_pte_update.sv
ptw_miss_store.sv
ptw_miss_queue_top.sv
tb_ptw_assertions.sv
tb_clk_gen.sv
tb_ptw_miss_queue.sv

// ==== Bender.yml ====
package:
  name: ptw_miss_queue

sources:
  - include_dirs:
      - .
    files:
      - ptw_mmu_pkg.sv
      - ptw_queue_pkg.sv
      - ptw_miss_match.sv
      - ptw_walk_select.sv
      - ptw_pte_update.sv
      - ptw_miss_store.sv
      - ptw_miss_queue_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ptw_assertions.sv
      - tb_clk_gen.sv
      - tb_ptw_miss_queue.sv
